// ==== sim.f ====
+incdir+verilog
verilog/dsp_ctrl_pkg.sv
verilog/ctrl_seq.sv
verilog/route_decode.sv
verilog/load_decode.sv
verilog/ctrl_reg.sv
verilog/dsp_ctrl.sv
bench/clk_gen.sv
bench/dsp_ctrl_assert.sv
bench/tb_dsp_ctrl.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_dsp_ctrl
FILELIST  := sim.f
OBJDIR    := obj_dir
SIM_BIN   := $(OBJDIR)/V$(TOP)
SOURCES   := $(wildcard verilog/*.sv verilog/*.svh bench/*.sv) $(FILELIST)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJDIR)

// ==== bench/tb_dsp_ctrl.sv ====
// Table-driven testbench for the decode controller
// Typed compare tasks, hold cycles and a watchdog
`timescale 1ns/10ps

`include "dsp_ctrl_config.svh"

module tb_dsp_ctrl;

    localparam int NUM_ROWS = 25;

    typedef struct {
        logic [`DSP_WORD_W-1:0]   instr;
        logic                     con;
        logic                     en;
        dsp_ctrl_pkg::seq_ctl_t   seq;
        dsp_ctrl_pkg::route_ctl_t route;
        dsp_ctrl_pkg::load_ctl_t  load;
        logic                     no_int;
    } row_t;

    logic                     clk;
    logic                     rst;
    logic                     instr_en;
    logic [`DSP_WORD_W-1:0]   instr;
    logic                     con_result;
    dsp_ctrl_pkg::seq_ctl_t   seq;
    dsp_ctrl_pkg::route_ctl_t route;
    dsp_ctrl_pkg::load_ctl_t  load;
    logic                     no_int;

    row_t rows[$];

    clk_gen u_clk (
        .clk (clk),
        .rst (rst)
    );

    dsp_ctrl DUT (
        .clk        (clk),
        .rst        (rst),
        .instr_en   (instr_en),
        .instr      (instr),
        .con_result (con_result),
        .seq        (seq),
        .route      (route),
        .load       (load),
        .no_int     (no_int)
    );

    // Post-modify with update, inc 0 minus one, 1 none, 2 plus one
    function automatic dsp_ctrl_pkg::ymod_t make_ymod(input logic [1:0] inc, input logic step);
        dsp_ctrl_pkg::ymod_t y;
        y.post_load = 1'b1;
        y.inc_sel   = dsp_ctrl_pkg::inc_sel_e'(inc);
        y.step_sel  = step;
        y.ksel      = 1'b0;
        return y;
    endfunction

    // Expected route group with the fixed fields of the word format
    function automatic dsp_ctrl_pkg::route_ctl_t make_route(
        input logic [15:0] w, input logic [2:0] r_field, input logic [2:0] rsel,
        input logic [1:0] a_field, input logic acc_sel, input logic st_a0h,
        input logic st_a1h, input logic ram_we, input dsp_ctrl_pkg::ymod_t ymod);
        dsp_ctrl_pkg::route_ctl_t r;
        r           = '0;
        r.t_field   = w[15:11];
        r.i_field   = w[11:0];
        r.dau_op    = w[10:5];
        r.short_imm = w[8:0];
        r.c_field   = w[4:0];
        r.y_field   = w[3:2];
        r.r_field   = r_field;
        r.rsel      = rsel;
        r.a_field   = a_field;
        r.acc_sel   = acc_sel;
        r.st_a0h    = st_a0h;
        r.st_a1h    = st_a1h;
        r.ram_we    = ram_we;
        r.ymod      = ymod;
        return r;
    endfunction

    // Live word with no operand routing
    function automatic dsp_ctrl_pkg::route_ctl_t plain_route(input logic [15:0] w);
        return make_route(w, 3'd0, 3'd0, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0, '0);
    endfunction

    task automatic add_row(input logic [15:0] w, input logic con, input logic en,
                           input dsp_ctrl_pkg::seq_ctl_t s,
                           input dsp_ctrl_pkg::route_ctl_t r,
                           input dsp_ctrl_pkg::load_ctl_t l, input logic ni);
        row_t row;
        row.instr  = w;
        row.con    = con;
        row.en     = en;
        row.seq    = s;
        row.route  = r;
        row.load   = l;
        row.no_int = ni;
        rows.push_back(row);
    endtask

    task automatic fail_now();
        $display("STATUS: FAIL");
        $fatal(1, "compare failed");
    endtask

    task automatic check_seq(input string tag, input dsp_ctrl_pkg::seq_ctl_t got,
                             input dsp_ctrl_pkg::seq_ctl_t exp);
        if (got !== exp) begin
            $display("error: %0t ns seq %s got %b expected %b", $time, tag, got, exp);
            fail_now();
        end
    endtask

    task automatic check_route(input string tag, input dsp_ctrl_pkg::route_ctl_t got,
                               input dsp_ctrl_pkg::route_ctl_t exp);
        if (got !== exp) begin
            $display("error: %0t ns route %s got %h expected %h", $time, tag, got, exp);
            fail_now();
        end
    endtask

    task automatic check_load(input string tag, input dsp_ctrl_pkg::load_ctl_t got,
                              input dsp_ctrl_pkg::load_ctl_t exp);
        if (got !== exp) begin
            $display("error: %0t ns load %s got %b expected %b", $time, tag, got, exp);
            fail_now();
        end
    endtask

    task automatic check_bit(input string tag, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error: %0t ns %s got %b expected %b", $time, tag, got, exp);
            fail_now();
        end
    endtask

    task automatic fill_table();
        dsp_ctrl_pkg::seq_ctl_t   s;
        dsp_ctrl_pkg::route_ctl_t rz;
        dsp_ctrl_pkg::route_ctl_t r;
        dsp_ctrl_pkg::load_ctl_t  l;
        logic [15:0]              junk;
        rz = '0;
        l  = '0;
        s         = '0;
        s.goto_ja = 1'b1;
        add_row(16'h0123, 1'b0, 1'b1, s, plain_route(16'h0123), l, 1'b0); // goto JA
        add_row(16'hFFFF, 1'b0, 1'b1, '0, rz, l, 1'b1); // Skipped word
        s         = '0;
        s.call_ja = 1'b1;
        add_row(16'h8045, 1'b0, 1'b1, s, plain_route(16'h8045), l, 1'b0); // call JA
        add_row(16'h1234, 1'b0, 1'b1, '0, rz, l, 1'b1);
        add_row(16'hD000, 1'b0, 1'b1, '0, plain_route(16'hD000), l, 1'b1); // if CON
        s         = '0;
        s.pc_halt = 1'b1;
        // goto B with the condition false
        add_row(16'hC000, 1'b0, 1'b1, s, plain_route(16'hC000), l, 1'b0);
        add_row(16'h0000, 1'b0, 1'b1, '0, rz, l, 1'b1);
        add_row(16'hD000, 1'b0, 1'b1, '0, plain_route(16'hD000), l, 1'b1);
        s        = '0;
        s.goto_b = 1'b1;
        add_row(16'hC100, 1'b0, 1'b1, s, plain_route(16'hC100), l, 1'b0); // iret ignores condition
        add_row(16'h0000, 1'b0, 1'b1, '0, rz, l, 1'b1);
        // R=imm into the arithmetic unit, r_field 5
        r = make_route(16'h5150, 3'd5, 3'd0, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0, '0);
        l              = '0;
        l.dau_imm_load = 1'b1;
        add_row(16'h5150, 1'b0, 1'b1, '0, r, l, 1'b0);
        l = '0;
        add_row(16'hABCD, 1'b0, 1'b1, '0, rz, l, 1'b1);
        // R=a0 into the ROM address unit, r_field 3
        s         = '0;
        s.pc_halt = 1'b1;
        r = make_route(16'h48B0, 3'd3, 3'd0, 2'd2, 1'b1, 1'b0, 1'b0, 1'b0, '0);
        l               = '0;
        l.xaau_acc_load = 1'b1;
        add_row(16'h48B0, 1'b0, 1'b1, s, r, l, 1'b0);
        l = '0;
        add_row(16'h0000, 1'b0, 1'b1, '0, rz, l, 1'b1);
        // R=Y with post increment
        r = make_route(16'h7821, 3'd2, 3'd0, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0,
                       make_ymod(2'd2, 1'b0));
        l          = '0;
        l.ram_load = 1'b1;
        add_row(16'h7821, 1'b0, 1'b1, s, r, l, 1'b0);
        l = '0;
        add_row(16'h0000, 1'b0, 1'b1, '0, rz, l, 1'b1);
        // Y=R with post decrement stores to RAM
        r = make_route(16'h6042, 3'd4, 3'd1, 2'd0, 1'b0, 1'b0, 1'b0, 1'b1,
                       make_ymod(2'd0, 1'b0));
        add_row(16'h6042, 1'b0, 1'b1, s, r, l, 1'b0);
        add_row(16'h0000, 1'b0, 1'b1, '0, rz, l, 1'b1);
        // F1 aT=Y into a0 high, ++j step
        r = make_route(16'h3C03, 3'd0, 3'd0, 2'd2, 1'b0, 1'b1, 1'b0, 1'b0,
                       make_ymod(2'd0, 1'b1));
        l            = '0;
        l.dau_dec_en = 1'b1;
        add_row(16'h3C03, 1'b0, 1'b1, '0, r, l, 1'b1);
        junk = 16'($urandom());
        add_row(junk, 1'b1, 1'b0, '0, r, l, 1'b1); // Strobe low, hold
        junk = 16'($urandom());
        add_row(junk, 1'b0, 1'b0, '0, r, l, 1'b1);
        // Dropped opcodes raise fault only
        s       = '0;
        s.fault = 1'b1;
        l       = '0;
        add_row(16'hF800, 1'b0, 1'b1, s, rz, l, 1'b1);
        add_row(16'hA800, 1'b0, 1'b1, s, rz, l, 1'b1);
        add_row(16'h7000, 1'b0, 1'b1, s, rz, l, 1'b1);
        // F1 Y form, a1 target, no high store
        r = make_route(16'h3200, 3'd0, 3'd0, 2'd1, 1'b0, 1'b0, 1'b0, 1'b0,
                       make_ymod(2'd1, 1'b0));
        l            = '0;
        l.dau_dec_en = 1'b1;
        add_row(16'h3200, 1'b0, 1'b1, '0, r, l, 1'b1);
    endtask

    initial begin
        #((NUM_ROWS + 20) * 100);
        $display("timeout, the test did not finish in time");
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        string tag;
        instr_en   = 1'b0;
        instr      = '0;
        con_result = 1'b0;
        void'($urandom(32'ha406_3f0b));
        fill_table();
        if (rows.size() != NUM_ROWS) begin
            $display("stimulus table has the wrong number of rows");
            fail_now();
        end
        @(negedge rst);
        @(posedge clk);
        #1;
        check_seq("reset", seq, '0);
        check_route("reset", route, '0);
        check_load("reset", load, '0);
        check_bit("reset no_int", no_int, 1'b1);
        foreach (rows[i]) begin
            instr      = rows[i].instr; // Driven 1 ns after the edge
            con_result = rows[i].con;
            instr_en   = rows[i].en;
            @(posedge clk);
            #1;
            tag = $sformatf("row %0d", i);
            check_seq(tag, seq, rows[i].seq);
            check_route(tag, route, rows[i].route);
            check_load(tag, load, rows[i].load);
            check_bit({tag, " no_int"}, no_int, rows[i].no_int);
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== bench/dsp_ctrl_assert.sv ====
// Concurrent checks on the decode controller outputs, bound to dsp_ctrl
`timescale 1ns/10ps

module dsp_ctrl_assert (
    input logic                     clk,
    input logic                     rst,
    input dsp_ctrl_pkg::seq_ctl_t   seq,
    input dsp_ctrl_pkg::route_ctl_t route,
    input dsp_ctrl_pkg::load_ctl_t  load
);

    // A taken jump never stalls the pc
    goto_vs_halt: assert property (@(posedge clk) disable iff (rst)
        !(seq.goto_ja && seq.pc_halt))
        else $error("goto_ja and pc_halt high together");

    // RAM cannot be written and read into a register at once
    ram_we_vs_load: assert property (@(posedge clk) disable iff (rst)
        !(route.ram_we && load.ram_load))
        else $error("ram_we and ram_load high together");

    reset_clears: assert property (@(posedge clk)
        rst |-> (seq == '0 && route == '0 && load == '0))
        else $error("outputs not zero during reset");

endmodule

bind dsp_ctrl dsp_ctrl_assert u_assert (
    .clk   (clk),
    .rst   (rst),
    .seq   (seq),
    .route (route),
    .load  (load)
);

// ==== bench/clk_gen.sv ====
// Testbench clock at 100 ns period and power-on reset pulse
`timescale 1ns/10ps

module clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0; // Release clear of the edge
    end

endmodule

// ==== verilog/dsp_ctrl.sv ====
// Decode and sequencing controller top: sequencer, two decoders
// and the registered control groups
`timescale 1ns/10ps

`include "dsp_ctrl_config.svh"

module dsp_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     instr_en,
    input  logic [`DSP_WORD_W-1:0]   instr,
    input  logic                     con_result,
    output dsp_ctrl_pkg::seq_ctl_t   seq,
    output dsp_ctrl_pkg::route_ctl_t route,
    output dsp_ctrl_pkg::load_ctl_t  load,
    output logic                     no_int
);

    logic                     live;
    dsp_ctrl_pkg::seq_ctl_t   seq_next;
    dsp_ctrl_pkg::route_ctl_t route_next;
    dsp_ctrl_pkg::load_ctl_t  load_next;

    ctrl_seq u_seq (
        .clk        (clk),
        .rst        (rst),
        .instr_en   (instr_en),
        .instr      (instr),
        .con_result (con_result),
        .live       (live),
        .no_int     (no_int),
        .seq_next   (seq_next)
    );

    route_decode u_route (
        .instr      (instr),
        .route_next (route_next)
    );

    load_decode u_load (
        .instr      (instr),
        .load_next  (load_next)
    );

    // Sequencer already zeroes its group on a skip and keeps fault
    ctrl_reg #(.payload_t(dsp_ctrl_pkg::seq_ctl_t)) u_seq_reg (
        .clk  (clk),
        .rst  (rst),
        .en   (instr_en),
        .live (1'b1),
        .d    (seq_next),
        .q    (seq)
    );

    ctrl_reg #(.payload_t(dsp_ctrl_pkg::route_ctl_t)) u_route_reg (
        .clk  (clk),
        .rst  (rst),
        .en   (instr_en),
        .live (live),
        .d    (route_next),
        .q    (route)
    );

    ctrl_reg #(.payload_t(dsp_ctrl_pkg::load_ctl_t)) u_load_reg (
        .clk  (clk),
        .rst  (rst),
        .en   (instr_en),
        .live (live),
        .d    (load_next),
        .q    (load)
    );

endmodule

// ==== verilog/ctrl_reg.sv ====
// Strobed output register for one decoded control group
`timescale 1ns/10ps

module ctrl_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     en,
    input  logic     live,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            q <= '0;
        end else if (en) begin
            if (live)
                q <= d;
            else
                q <= '0; // Skipped or illegal word
        end
    end

endmodule

// ==== verilog/load_decode.sv ====
// Destination load strobes and arithmetic unit decode strobes
`timescale 1ns/10ps

`include "dsp_ctrl_config.svh"

module load_decode (
    input  logic [`DSP_WORD_W-1:0]  instr,
    output dsp_ctrl_pkg::load_ctl_t load_next
);

    dsp_ctrl_pkg::load_ctl_t l;
    logic [2:0] dst;  // Destination unit of R=imm and R=Y
    logic [1:0] adst; // Destination unit of R=aN

    assign dst  = instr[9:7];
    assign adst = instr[8:7];

    always_comb begin
        l = '0;
        casez (instr[15:11])
            `OP_SHORT_IMM: l.short_load = 1'b1;
            `OP_AT_R:      l.dau_rmux_load = 1'b1;
            `OP_R_ACC0, `OP_R_ACC1: begin
                l.acc_load      = (adst == 2'b00); // RAM address unit
                l.xaau_acc_load = (adst == 2'b01); // ROM address unit
                l.dau_acc_load  = (adst == 2'b10);
            end
            `OP_R_IMM: begin
                l.long_load     = (dst == 3'b000);
                l.xaau_imm_load = (dst == 3'b001);
                l.dau_imm_load  = (dst == 3'b010);
            end
            `OP_R_Y: begin
                l.ram_load      = (dst == 3'b000);
                l.xaau_ram_load = (dst == 3'b001);
                l.dau_ram_load  = (dst == 3'b010);
            end
            `OP_F1_Y, `OP_F1_ATY, `OP_F1_YSTORE, `OP_F1_A0L, `OP_F1_A1L:
                l.dau_dec_en = 1'b1;
            `OP_F1_XY, `OP_F1_YK: begin
                l.dau_dec_en   = 1'b1;
                l.dau_ram_load = 1'b1; // x or y from RAM
            end
            `OP_IF_CON_F2: begin
                l.dau_dec_en  = 1'b1;
                l.dau_special = 1'b1;
            end
            default: ;
        endcase
    end

    assign load_next = l;

endmodule

// ==== verilog/route_decode.sv ====
// Operand routing decode: register, accumulator, RAM write
// and Y post-modify fields of the program word
`timescale 1ns/10ps

`include "dsp_ctrl_config.svh"

module route_decode (
    input  logic [`DSP_WORD_W-1:0]   instr,
    output dsp_ctrl_pkg::route_ctl_t route_next
);

    dsp_ctrl_pkg::route_ctl_t r;
    logic [`DSP_R_W-1:0]      y_reg; // y or yl

    assign y_reg = instr[4] ? 3'd1 : 3'd2;

    always_comb begin
        r           = '0;
        // Fixed fields straight from the word
        r.t_field   = instr[15:11];
        r.i_field   = instr[11:0];
        r.c_field   = instr[4:0];
        r.y_field   = instr[3:2];
        r.dau_op    = instr[10:5];
        r.short_imm = instr[8:0];

        casez (instr[15:11])
            `OP_SHORT_IMM: r.r_field = instr[11:9] ^ 3'b100; // j, k, rb, re
            `OP_AT_R: begin
                r.r_field = instr[6:4];
                r.rsel    = instr[8:6];
                r.st_a0h  = instr[10];
                r.st_a1h  = ~instr[10];
            end
            `OP_R_ACC0, `OP_R_ACC1: begin
                r.r_field = instr[6:4];
                r.a_field = {1'b1, instr[12]};
                r.acc_sel = 1'b1;
            end
            `OP_R_IMM: r.r_field = instr[6:4];
            `OP_R_Y, `OP_Y_R: begin
                r.r_field = instr[6:4];
                r.rsel    = instr[8:6];
                r.ram_we  = (instr[15:11] == 5'b01100); // Y=R stores
                r.ymod    = dsp_ctrl_pkg::ymod_decode(instr[1:0]);
            end
            `OP_F1_Y, `OP_F1_ATY: begin
                r.a_field = instr[10:9];
                if (instr[11]) begin  // aT=Y form writes the high half
                    r.st_a0h = instr[10];
                    r.st_a1h = ~instr[10];
                end
                r.ymod = dsp_ctrl_pkg::ymod_decode(instr[1:0]);
            end
            `OP_IF_CON_F2: r.a_field = instr[10:9];
            `OP_F1_XY: begin
                r.r_field = 3'd0; // x register
                r.ymod    = dsp_ctrl_pkg::ymod_decode(instr[1:0]);
            end
            `OP_F1_YSTORE: begin
                r.r_field = y_reg;
                r.rsel    = 3'b100;  // DAU
                r.ram_we  = 1'b1;
                r.ymod    = dsp_ctrl_pkg::ymod_decode(instr[1:0]);
            end
            `OP_F1_YK: begin
                r.r_field = y_reg;
                r.ymod    = dsp_ctrl_pkg::ymod_decode(instr[1:0]);
            end
            `OP_F1_A0L, `OP_F1_A1L: begin
                r.r_field = y_reg;
                r.rsel    = 3'b010;  // Accumulator path
                r.acc_sel = 1'b1;
                r.ram_we  = 1'b1;
                r.a_field = {instr[4], ~instr[15]};
                r.ymod    = dsp_ctrl_pkg::ymod_decode(instr[1:0]);
            end
            default: ; // Fixed fields only
        endcase
    end

    assign route_next = r;

endmodule

// ==== verilog/ctrl_seq.sv ====
// Instruction sequencer: skip and condition flags, branch decode,
// pc halt, word length and illegal-opcode fault
`timescale 1ns/10ps

`include "dsp_ctrl_config.svh"

module ctrl_seq (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instr_en,
    input  logic [`DSP_WORD_W-1:0] instr,
    input  logic                   con_result,
    output logic                   live,
    output logic                   no_int,
    output dsp_ctrl_pkg::seq_ctl_t seq_next
);

    logic skip_q;   // Next word is the second half of an instruction
    logic cond_q;   // Previous word was if CON
    logic con_ok;
    logic dbl;      // Two-word instruction
    logic illegal;
    logic set_cond;
    logic taken;
    dsp_ctrl_pkg::seq_ctl_t dec;

    assign con_ok = ~cond_q | con_result;
    assign no_int = ~skip_q;
    assign live   = ~skip_q & ~illegal;

    always_comb begin
        dec      = '0;
        dbl      = 1'b0;
        illegal  = 1'b0;
        set_cond = 1'b0;
        taken    = 1'b0;
        casez (instr[15:11])
            `OP_GOTO_JA: begin
                dec.goto_ja = con_ok;
                dec.pc_halt = ~con_ok;
                dbl         = 1'b1;
            end
            `OP_CALL_JA: begin
                dec.call_ja = con_ok;
                dec.pc_halt = ~con_ok;
                dbl         = 1'b1;
            end
            `OP_GOTO_B: begin
                taken       = con_ok | (instr[10:8] == 3'd1); // iret always taken
                dec.goto_b  = taken;
                dec.pc_halt = ~taken;
                dbl         = 1'b1;
            end
            `OP_R_IMM: dbl = 1'b1; // Immediate in next word
            `OP_AT_R, `OP_R_ACC0, `OP_R_ACC1, `OP_R_Y, `OP_Y_R,
            `OP_F1_YSTORE, `OP_F1_A0L, `OP_F1_A1L: begin
                dbl         = 1'b1;
                dec.pc_halt = 1'b1;
            end
            `OP_SHORT_IMM, `OP_F1_Y, `OP_F1_ATY, `OP_IF_CON_F2,
            `OP_F1_XY, `OP_F1_YK: ; // Single word, no sequencing effect
            `OP_IF_CON: begin
                if (!instr[10])
                    set_cond = 1'b1;
                else
                    illegal = 1'b1; // icall form
            end
            default: illegal = 1'b1;
        endcase
        dec.fault = illegal;
    end

    // Skipped word clears the whole group
    assign seq_next = skip_q ? '0 : dec;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            skip_q <= 1'b0;
            cond_q <= 1'b0;
        end else if (instr_en) begin
            skip_q <= live & dbl;
            cond_q <= live & set_cond;
        end
    end

endmodule

// ==== verilog/dsp_ctrl_pkg.sv ====
// Control group structs, Y post-modify encoding and its decode function

`include "dsp_ctrl_config.svh"

package dsp_ctrl_pkg;

    // Y pointer increment select
    typedef enum logic [1:0] {
        INC_M1   = 2'd0,
        INC_NONE = 2'd1,
        INC_P1   = 2'd2
    } inc_sel_e;

    typedef struct packed {
        logic     post_load; // Update pointer after access
        inc_sel_e inc_sel;
        logic     step_sel;  // Use the j step
        logic     ksel;
    } ymod_t;

    // Sequencing outputs towards the ROM address unit
    typedef struct packed {
        logic goto_ja;
        logic goto_b;
        logic call_ja;
        logic pc_halt;
        logic fault;
    } seq_ctl_t;

    typedef struct packed {
        logic [`DSP_T_W-1:0] t_field;
        logic [`DSP_R_W-1:0] r_field;
        logic [2:0]          rsel;     // Register mux source
        logic [`DSP_A_W-1:0] a_field;
        logic [1:0]          y_field;
        logic [4:0]          c_field;
        logic [11:0]         i_field;
        logic [8:0]          short_imm;
        logic [5:0]          dau_op;
        logic                acc_sel;
        logic                st_a0h;
        logic                st_a1h;
        logic                ram_we;
        ymod_t               ymod;
    } route_ctl_t;

    typedef struct packed {
        logic short_load;
        logic long_load;
        logic acc_load;
        logic ram_load;
        logic xaau_imm_load;
        logic xaau_acc_load;
        logic xaau_ram_load;
        logic dau_imm_load;
        logic dau_acc_load;
        logic dau_ram_load;
        logic dau_rmux_load;
        logic dau_dec_en;
        logic dau_special;
    } load_ctl_t;

    // Low two word bits select *rN, *rN++, *rN-- or *rN++j
    function automatic ymod_t ymod_decode(input logic [1:0] mode);
        ymod_t m;
        m.post_load = 1'b1;
        m.step_sel  = 1'b0;
        m.ksel      = 1'b0;
        case (mode)
            2'd0:    m.inc_sel = INC_NONE;
            2'd1:    m.inc_sel = INC_P1;
            2'd2:    m.inc_sel = INC_M1;
            default: begin
                m.inc_sel  = INC_M1; // Ignored, step comes from j
                m.step_sel = 1'b1;
            end
        endcase
        return m;
    endfunction

endpackage

// ==== verilog/dsp_ctrl_config.svh ====
// Word and field widths for the DSP16 decode controller
// Opcode patterns of the T field, wildcards for casez use
`ifndef DSP_CTRL_CONFIG_SVH
`define DSP_CTRL_CONFIG_SVH

`define DSP_WORD_W 16
`define DSP_T_W 5
`define DSP_R_W 3
`define DSP_A_W 2

`define OP_GOTO_JA    5'b0000?
`define OP_CALL_JA    5'b1000?
`define OP_GOTO_B     5'b11000
`define OP_SHORT_IMM  5'b0001?
`define OP_AT_R       5'b01000
`define OP_R_ACC0     5'b01001
`define OP_R_ACC1     5'b01011
`define OP_R_IMM      5'b01010
`define OP_R_Y        5'b01111
`define OP_Y_R        5'b01100
`define OP_F1_Y       5'b00110
`define OP_F1_ATY     5'b00111
`define OP_IF_CON_F2  5'b10011
`define OP_F1_XY      5'b10110
`define OP_F1_YSTORE  5'b10100
`define OP_F1_YK      5'b10111
`define OP_F1_A0L     5'b11100
`define OP_F1_A1L     5'b00100
`define OP_IF_CON     5'b11010

`endif
